// ==== all.f ====
+incdir+src
src/music_pkg.sv
src/score_rom_decoder.sv
src/note_sequencer.sv
src/tone_generator.sv
src/music_player.sv
sim/tb_clock_gen.sv
sim/tb_music_player.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal --top-module tb_music_player -f all.f &&
  ./obj_dir/Vtb_music_player || exit 1

// ==== sim/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== sim/tb_music_player.sv ====
`include "music_consts.svh"

module tb_music_player;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int BEATS        = 2;
  localparam int CLK_SHIFT    = 8;
  localparam int NUM_ENTRIES  = 16;
  localparam int NOTE_TIMEOUT = 1000;
  localparam int SONG_TIMEOUT = 20000;
  localparam int HOLD_CYCLES  = 10;
  localparam int ABORT_RISES  = 6;
  localparam int ABORT_WINDOW = 2000;

  // score copy, kind 0 note, 1 rest, 2 end
  localparam int ENTRY_KIND [NUM_ENTRIES] = '{0, 0, 0, 0, 1, 0, 0, 0, 0, 1, 0, 0, 0, 0, 1, 2};
  localparam int ENTRY_LEN [NUM_ENTRIES] = '{2, 2, 2, 2, 2, 2, 2, 2, 2, 4, 2, 2, 2, 2, 2, 0};
  localparam int ENTRY_RAW [NUM_ENTRIES] = '{
    `M6, `M2, `M3, `D6, `REST_PERIOD,
    `M6, `M2, `M3, `D6, `REST_PERIOD,
    `M6, `M2, `M3, `D6, `REST_PERIOD, 0
  };

  logic clk;
  logic rst_n;
  logic req;
  logic ack;
  logic beep;
  int   exp_rises[$];  // rise times counted from the first note load

  tb_clock_gen i_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  music_player #(
    .beats_per_step (BEATS),
    .clk_shift      (CLK_SHIFT)
  ) i_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .ack   (ack),
    .beep  (beep)
  );

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_equal(input string name, input int got, input int exp);
    assert (got == exp) else begin
      stop_on_error($sformatf("ERR %s = 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic start_song();
    @(posedge clk);
    req <= 1'b1;
  endtask

  task automatic stop_request();
    @(posedge clk);
    req <= 1'b0;
  endtask

  // each note runs len*beats periods, the next load comes 2 cycles after its last wave
  function automatic void build_expected_rises();
    int t;
    int p;
    t = 0;
    exp_rises.delete();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (ENTRY_KIND[i] == 2) break;
      p = ENTRY_RAW[i] >> CLK_SHIFT;
      if (ENTRY_KIND[i] == 0) begin
        for (int k = 0; k < ENTRY_LEN[i] * BEATS; k++) begin
          exp_rises.push_back(t + p / 2 + k * p);  // low half first
        end
      end
      t += ENTRY_LEN[i] * BEATS * p + 2;
    end
  endfunction

  task automatic measure_first_note(output int high, output int period);
    int n;
    int low;
    n = 0;
    high = 0;
    low = 0;
    @(negedge clk);
    while (!beep) begin
      @(negedge clk);
      n++;
      assert (n < NOTE_TIMEOUT) else stop_on_error("no beep after the request");
    end
    while (beep) begin
      @(negedge clk);
      high++;
      assert (high < NOTE_TIMEOUT) else stop_on_error("beep stuck high");
    end
    while (!beep) begin
      @(negedge clk);
      low++;
      assert (low < NOTE_TIMEOUT) else stop_on_error("no second beep pulse");
    end
    period = high + low;
  endtask

  task automatic wait_for_ack();
    int n;
    n = 0;
    while (!ack) begin
      @(negedge clk);
      n++;
      assert (n < SONG_TIMEOUT) else stop_on_error("ack did not rise at the end of the song");
    end
  endtask

  task automatic release_song();
    int n;
    n = 0;
    stop_request();
    @(negedge clk);
    while (ack) begin
      @(negedge clk);
      n++;
      assert (n < 4) else stop_on_error("ack did not fall after req dropped");
    end
  endtask

  task automatic test_reset();
    int n;
    n = 0;
    @(negedge clk);
    while (!rst_n) begin
      check_equal("ack", ack, 0);
      check_equal("beep", beep, 0);
      @(negedge clk);
      n++;
      assert (n < 20) else stop_on_error("reset was never released");
    end
    repeat (4) begin
      check_equal("ack", ack, 0);
      check_equal("beep", beep, 0);
      @(negedge clk);
    end
  endtask

  task automatic test_first_note();
    int high;
    int period;
    int p;
    p = ENTRY_RAW[0] >> CLK_SHIFT;
    start_song();
    measure_first_note(high, period);
    check_equal("first note period", period, p);
    check_equal("first note high time", high, p - p / 2);
    wait_for_ack();
    release_song();
  endtask

  task automatic test_note_sequence();
    int   rises[$];
    int   cyc;
    logic prev;
    cyc = 0;
    prev = 1'b0;
    build_expected_rises();
    start_song();
    while (!ack) begin
      @(negedge clk);
      cyc++;
      assert (cyc < SONG_TIMEOUT) else stop_on_error("song did not finish in time");
      if (beep && !prev) begin
        rises.push_back(cyc);
      end
      prev = beep;
    end
    check_equal("beep rise count", rises.size(), exp_rises.size());
    foreach (rises[i]) begin
      check_equal($sformatf("beep rise %0d offset", i),
                  rises[i] - rises[0], exp_rises[i] - exp_rises[0]);
    end
  endtask

  task automatic test_handshake();
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check_equal("ack", ack, 1);
      check_equal("beep", beep, 0);
    end
    stop_request();
    @(posedge clk);  // sequencer sees req low here
    @(negedge clk);
    check_equal("ack", ack, 0);
    check_equal("beep", beep, 0);
  endtask

  task automatic test_replay();
    int high;
    int period;
    start_song();
    measure_first_note(high, period);
    check_equal("replay first period", period, ENTRY_RAW[0] >> CLK_SHIFT);
    wait_for_ack();
    release_song();
  endtask

  task automatic test_abort();
    int   n;
    int   seen;
    logic prev;
    n = 0;
    seen = 0;
    prev = 1'b0;
    start_song();
    while (seen < ABORT_RISES) begin
      @(negedge clk);
      n++;
      assert (n < SONG_TIMEOUT) else stop_on_error("song never reached the abort point");
      if (beep && !prev) begin
        seen++;
      end
      prev = beep;
    end
    stop_request();
    @(posedge clk);
    @(negedge clk);
    repeat (ABORT_WINDOW) begin
      check_equal("beep", beep, 0);
      check_equal("ack", ack, 0);
      @(negedge clk);
    end
  endtask

  initial begin
    req = 1'b0;
    test_reset();
    test_first_note();
    test_note_sequence();
    test_handshake();
    test_replay();
    test_abort();
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== src/music_consts.svh ====
`ifndef MUSIC_CONSTS_SVH
`define MUSIC_CONSTS_SVH

`define PERIOD_W 17
`define LEN_W 5
`define ADDR_W 4
`define BEATS_W 9
`define BEATS_DEFAULT 300

// tone periods in clock cycles at 50 MHz
`define D5  17'd127551
`define D51 17'd120482
`define D6  17'd113636
`define D61 17'd107296
`define D7  17'd101215

`define M1  17'd95602
`define M11 17'd90253
`define M2  17'd85178
`define M21 17'd80386
`define M3  17'd75872
`define M4  17'd71633
`define M41 17'd67568
`define M5  17'd63775
`define M51 17'd60168
`define M6  17'd56818
`define M61 17'd53648
`define M7  17'd50607

`define H1  17'd47801
`define H11 17'd45086
`define H2  17'd42553
`define H21 17'd40161
`define H3  17'd37936
`define H4  17'd35791
`define H41 17'd33784
`define H5  17'd31888
`define H51 17'd30102
`define H6  17'd28409
`define H61 17'd26810
`define H7  17'd25303

`define HH1 17'd23883
`define HH2 17'd22543

`define REST_PERIOD 17'd2500  // silent, only paces the rest length

// score entry field codes
`define KIND_NOTE 1'b0
`define KIND_CTRL 1'b1
`define OCT_LOW  2'd0
`define OCT_MID  2'd1
`define OCT_HIGH 2'd2
`define OCT_TOP  2'd3
`define OP_REST 2'd0
`define OP_END  2'd1

`endif

// ==== src/music_pkg.sv ====
`include "music_consts.svh"

package music_pkg;

  typedef logic [`PERIOD_W-1:0] period_t;  // tone period in clocks

  typedef logic [`LEN_W-1:0] note_len_t;  // entry length in steps

  // note view of a score word
  typedef struct packed {
    logic       kind;    // 0 for a note
    logic [1:0] octave;  // low, middle, high, top
    logic [2:0] degree;  // 1 to 7
    logic       sharp;
    note_len_t  len;
  } note_entry_t;

  // control view of a score word
  typedef struct packed {
    logic       kind;    // 1 for control
    logic [1:0] op;      // rest or end
    logic [3:0] unused;
    note_len_t  len;
  } ctrl_entry_t;

  // the kind bit sits in the same place in both views,
  // so the decoder reads it from either one and picks the view
  typedef union packed {
    note_entry_t note;
    ctrl_entry_t ctrl;
  } score_entry_t;

endpackage

// ==== src/music_player.sv ====
`include "music_consts.svh"

module music_player #(
  parameter int unsigned beats_per_step = `BEATS_DEFAULT,
  parameter int unsigned clk_shift      = 0
) (
  input  logic clk,
  input  logic rst_n,
  input  logic req,
  output logic ack,
  output logic beep
);

  import music_pkg::*;

  logic [`ADDR_W-1:0] step_addr;
  period_t            period;
  note_len_t          note_len;
  logic               is_rest;
  logic               is_end;
  logic               note_load;
  logic               playing;
  logic               wave_done;
  logic               tone;

  score_rom_decoder #(
    .clk_shift (clk_shift)
  ) i_decoder (
    .clk       (clk),
    .rst_n     (rst_n),
    .step_addr (step_addr),
    .period    (period),
    .note_len  (note_len),
    .is_rest   (is_rest),
    .is_end    (is_end)
  );

  note_sequencer #(
    .beats_per_step (beats_per_step)
  ) i_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .note_len  (note_len),
    .is_end    (is_end),
    .wave_done (wave_done),
    .ack       (ack),
    .playing   (playing),
    .note_load (note_load),
    .step_addr (step_addr)
  );

  tone_generator i_tone (
    .clk       (clk),
    .rst_n     (rst_n),
    .note_load (note_load),
    .is_rest   (is_rest),
    .period    (period),
    .tone      (tone),
    .wave_done (wave_done)
  );

  assign beep = tone & playing;  // quiet when idle or aborted

endmodule

// ==== src/note_sequencer.sv ====
`include "music_consts.svh"

module note_sequencer #(
  parameter int unsigned beats_per_step = `BEATS_DEFAULT
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req,
  input  music_pkg::note_len_t note_len,
  input  logic                 is_end,
  input  logic                 wave_done,
  output logic                 ack,
  output logic                 playing,
  output logic                 note_load,
  output logic [`ADDR_W-1:0]   step_addr
);

  localparam int CNT_W = `LEN_W + `BEATS_W;
  localparam logic [`BEATS_W-1:0] BEATS = beats_per_step[`BEATS_W-1:0];

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_FETCH = 2'd1;
  localparam logic [1:0] ST_PLAY  = 2'd2;
  localparam logic [1:0] ST_DONE  = 2'd3;

  logic [1:0]       state;
  logic             fetch_ready;  // decoder output matches step_addr
  logic [CNT_W-1:0] beat_cnt;     // oscillations played in this entry
  logic [CNT_W-1:0] beat_total;
  logic             step_end;

  assign beat_total = note_len * BEATS;
  assign step_end   = wave_done && (beat_cnt == beat_total - 1'b1);

  assign note_load = (state == ST_FETCH) && fetch_ready && !is_end && req;
  assign playing   = (state == ST_FETCH) || (state == ST_PLAY);
  assign ack       = (state == ST_DONE);  // held until req drops

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= ST_IDLE;
      fetch_ready <= 1'b0;
      beat_cnt    <= '0;
      step_addr   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req) begin
            state       <= ST_FETCH;
            step_addr   <= '0;
            fetch_ready <= 1'b0;
          end
        end
        ST_FETCH: begin
          if (!req) begin
            state <= ST_IDLE;  // abort
          end else if (!fetch_ready) begin
            fetch_ready <= 1'b1;
          end else if (is_end) begin
            state <= ST_DONE;
          end else begin
            state    <= ST_PLAY;
            beat_cnt <= '0;
          end
        end
        ST_PLAY: begin
          if (!req) begin
            state <= ST_IDLE;
          end else if (step_end) begin
            step_addr   <= step_addr + 1'b1;
            fetch_ready <= 1'b0;
            state       <= ST_FETCH;
          end else if (wave_done) begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        ST_DONE: begin
          if (!req) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== src/score_rom_decoder.sv ====
`include "music_consts.svh"

module score_rom_decoder #(
  parameter int unsigned clk_shift = 0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`ADDR_W-1:0]   step_addr,
  output music_pkg::period_t   period,
  output music_pkg::note_len_t note_len,
  output logic                 is_rest,
  output logic                 is_end
);

  import music_pkg::*;

  // run-length coded opening of the song
  localparam score_entry_t SCORE [2**`ADDR_W] = '{
    {`KIND_NOTE, `OCT_MID, 3'd6, 1'b0, 5'd2},  // M6
    {`KIND_NOTE, `OCT_MID, 3'd2, 1'b0, 5'd2},  // M2
    {`KIND_NOTE, `OCT_MID, 3'd3, 1'b0, 5'd2},  // M3
    {`KIND_NOTE, `OCT_LOW, 3'd6, 1'b0, 5'd2},  // D6
    {`KIND_CTRL, `OP_REST, 4'd0, 5'd2},
    {`KIND_NOTE, `OCT_MID, 3'd6, 1'b0, 5'd2},
    {`KIND_NOTE, `OCT_MID, 3'd2, 1'b0, 5'd2},
    {`KIND_NOTE, `OCT_MID, 3'd3, 1'b0, 5'd2},
    {`KIND_NOTE, `OCT_LOW, 3'd6, 1'b0, 5'd2},
    {`KIND_CTRL, `OP_REST, 4'd0, 5'd4},        // long rest
    {`KIND_NOTE, `OCT_MID, 3'd6, 1'b0, 5'd2},
    {`KIND_NOTE, `OCT_MID, 3'd2, 1'b0, 5'd2},
    {`KIND_NOTE, `OCT_MID, 3'd3, 1'b0, 5'd2},
    {`KIND_NOTE, `OCT_LOW, 3'd6, 1'b0, 5'd2},
    {`KIND_CTRL, `OP_REST, 4'd0, 5'd2},
    {`KIND_CTRL, `OP_END,  4'd0, 5'd0}
  };

  score_entry_t entry;
  period_t      raw_period;
  logic         hit;  // note has a table entry
  period_t      period_d;
  note_len_t    len_d;
  logic         rest_d;
  logic         end_d;

  always_comb begin
    entry      = SCORE[step_addr];
    raw_period = `REST_PERIOD;
    hit        = 1'b0;
    if (entry.note.kind == `KIND_NOTE) begin
      hit = 1'b1;
      case ({entry.note.octave, entry.note.degree, entry.note.sharp})
        {`OCT_LOW,  3'd5, 1'b0}: raw_period = `D5;
        {`OCT_LOW,  3'd5, 1'b1}: raw_period = `D51;
        {`OCT_LOW,  3'd6, 1'b0}: raw_period = `D6;
        {`OCT_LOW,  3'd6, 1'b1}: raw_period = `D61;
        {`OCT_LOW,  3'd7, 1'b0}: raw_period = `D7;
        {`OCT_MID,  3'd1, 1'b0}: raw_period = `M1;
        {`OCT_MID,  3'd1, 1'b1}: raw_period = `M11;
        {`OCT_MID,  3'd2, 1'b0}: raw_period = `M2;
        {`OCT_MID,  3'd2, 1'b1}: raw_period = `M21;
        {`OCT_MID,  3'd3, 1'b0}: raw_period = `M3;
        {`OCT_MID,  3'd4, 1'b0}: raw_period = `M4;
        {`OCT_MID,  3'd4, 1'b1}: raw_period = `M41;
        {`OCT_MID,  3'd5, 1'b0}: raw_period = `M5;
        {`OCT_MID,  3'd5, 1'b1}: raw_period = `M51;
        {`OCT_MID,  3'd6, 1'b0}: raw_period = `M6;
        {`OCT_MID,  3'd6, 1'b1}: raw_period = `M61;
        {`OCT_MID,  3'd7, 1'b0}: raw_period = `M7;
        {`OCT_HIGH, 3'd1, 1'b0}: raw_period = `H1;
        {`OCT_HIGH, 3'd1, 1'b1}: raw_period = `H11;
        {`OCT_HIGH, 3'd2, 1'b0}: raw_period = `H2;
        {`OCT_HIGH, 3'd2, 1'b1}: raw_period = `H21;
        {`OCT_HIGH, 3'd3, 1'b0}: raw_period = `H3;
        {`OCT_HIGH, 3'd4, 1'b0}: raw_period = `H4;
        {`OCT_HIGH, 3'd4, 1'b1}: raw_period = `H41;
        {`OCT_HIGH, 3'd5, 1'b0}: raw_period = `H5;
        {`OCT_HIGH, 3'd5, 1'b1}: raw_period = `H51;
        {`OCT_HIGH, 3'd6, 1'b0}: raw_period = `H6;
        {`OCT_HIGH, 3'd6, 1'b1}: raw_period = `H61;
        {`OCT_HIGH, 3'd7, 1'b0}: raw_period = `H7;
        {`OCT_TOP,  3'd1, 1'b0}: raw_period = `HH1;
        {`OCT_TOP,  3'd2, 1'b0}: raw_period = `HH2;
        default:                 hit = 1'b0;  // unknown tone plays as a rest
      endcase
    end
  end

  assign period_d = raw_period >> clk_shift;
  assign len_d    = entry.note.len;  // same bits in both views
  assign end_d    = (entry.ctrl.kind == `KIND_CTRL) && (entry.ctrl.op == `OP_END);
  assign rest_d   = (entry.ctrl.kind == `KIND_CTRL) ? !end_d : !hit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      is_rest <= 1'b0;
      is_end  <= 1'b0;
    end else begin
      is_rest <= rest_d;
      is_end  <= end_d;
    end
  end

  always_ff @(posedge clk) begin
    period   <= period_d;
    note_len <= len_d;
  end

endmodule

// ==== src/tone_generator.sv ====
`include "music_consts.svh"

module tone_generator (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               note_load,
  input  logic               is_rest,
  input  music_pkg::period_t period,
  output logic               tone,
  output logic               wave_done
);

  import music_pkg::*;

  period_t cur_period;  // period of the note being played
  period_t cnt;
  logic    cur_rest;
  logic    wrap;

  assign wrap = (cnt == cur_period - 1'b1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_period <= '0;
      cur_rest   <= 1'b1;  // silent until the first note
      cnt        <= '0;
    end else if (note_load) begin
      cur_period <= period;
      cur_rest   <= is_rest;
      cnt        <= '0;
    end else if (wrap) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // low first half, high second half, odd periods give the extra cycle to the high half
  assign tone      = !cur_rest && (cnt >= (cur_period >> 1));
  assign wave_done = wrap;

endmodule
